// File: verilog/ibuf_consts.svh
`ifndef IBUF_CONSTS_SVH
`define IBUF_CONSTS_SVH

//////////////////////////////////////////////////////////////////////
// Buffer geometry
//////////////////////////////////////////////////////////////////////

// Entry count, must stay a power of two so the pointers wrap freely
`define IBUF_DEPTH 16

// Instruction word and PC width
`define IBUF_XLEN 32

//////////////////////////////////////////////////////////////////////
// Pipeline widths
//////////////////////////////////////////////////////////////////////

// Fetch slots offered per cycle
`define IBUF_FETCH_W 3

// Decode lanes served per cycle
`define IBUF_DECODE_W 3

//////////////////////////////////////////////////////////////////////
// Idle word
//////////////////////////////////////////////////////////////////////

// addi x0, x0, 0
`define IBUF_NOP 32'h0000_0013

`endif

// File: verilog/ibuf_pkg.sv
`include "ibuf_consts.svh"

package ibuf_pkg;

    // Instruction word as fetched
    typedef logic [`IBUF_XLEN-1:0] inst_t;

    // Program counter
    typedef logic [`IBUF_XLEN-1:0] addr_t;

    // Entry index into the circular storage
    typedef logic [$clog2(`IBUF_DEPTH)-1:0] ptr_t;

    // Occupancy 0 to IBUF_DEPTH, one bit wider than a pointer
    typedef logic [$clog2(`IBUF_DEPTH):0] count_t;

    // One bit per fetch slot or decode lane
    typedef logic [`IBUF_FETCH_W-1:0] lane_mask_t;

endpackage

// File: verilog/ibuf_write_ctrl.sv
`timescale 1ns/1ps

`include "ibuf_consts.svh"

module ibuf_write_ctrl
    import ibuf_pkg::*;
(
    input  lane_mask_t fetch_valid_i,
    input  logic       fetch_ready_i,
    output lane_mask_t wr_en_o,
    output ptr_t       wr_offset0_o,
    output ptr_t       wr_offset1_o,
    output ptr_t       wr_offset2_o,
    output count_t     wr_count_o
);

    lane_mask_t wr_en;
    ptr_t       offset [`IBUF_FETCH_W];
    count_t     total;

    // Nothing is accepted while the buffer holds off fetch
    assign wr_en = fetch_ready_i ? fetch_valid_i : '0;

    //////////////////////////////////////////////////////////////////////
    // Packing of the valid slots
    //////////////////////////////////////////////////////////////////////

    // Each slot lands after the enabled slots below it,
    // so a mask like 3'b101 fills two adjacent entries
    always_comb begin
        total = '0;
        for (int i = 0; i < `IBUF_FETCH_W; i++) begin
            offset[i] = ptr_t'(total);
            total = total + count_t'(wr_en[i]);
        end
    end

    assign wr_en_o = wr_en;

    assign wr_offset0_o = offset[0];
    assign wr_offset1_o = offset[1];
    assign wr_offset2_o = offset[2];

    // Tail advance for this cycle
    assign wr_count_o = total;

endmodule

// File: verilog/ibuf_read_ctrl.sv
`timescale 1ns/1ps

`include "ibuf_consts.svh"

module ibuf_read_ctrl
    import ibuf_pkg::*;
(
    input  lane_mask_t decode_ready_i,
    input  count_t     readable_count_i,
    output lane_mask_t decode_valid_o,
    output ptr_t       rd_offset0_o,
    output ptr_t       rd_offset1_o,
    output ptr_t       rd_offset2_o,
    output count_t     rd_count_o
);

    lane_mask_t grant;
    ptr_t       offset [`IBUF_DECODE_W];
    count_t     ready_prefix;
    count_t     granted;

    //////////////////////////////////////////////////////////////////////
    // Lane grant
    //////////////////////////////////////////////////////////////////////

    // Ready lanes are served oldest first in lane order.
    // A lane is granted only while the ready lanes up to it still fit
    // into what is stored.
    always_comb begin
        grant        = '0;
        ready_prefix = '0;
        granted      = '0;
        for (int k = 0; k < `IBUF_DECODE_W; k++) begin
            // Entry this lane takes if granted
            offset[k] = ptr_t'(granted);
            if (decode_ready_i[k]) begin
                ready_prefix = ready_prefix + 1'b1;
                if (ready_prefix <= readable_count_i) begin
                    grant[k] = 1'b1;
                    granted  = granted + 1'b1;
                end
            end
        end
    end

    assign decode_valid_o = grant;

    assign rd_offset0_o = offset[0];
    assign rd_offset1_o = offset[1];
    assign rd_offset2_o = offset[2];

    // Head advance for this cycle
    assign rd_count_o = granted;

endmodule

// File: verilog/ibuf_occupancy.sv
`timescale 1ns/1ps

`include "ibuf_consts.svh"

module ibuf_occupancy
    import ibuf_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  logic   flush_i,
    input  count_t wr_count_i,
    input  count_t rd_count_i,
    output ptr_t   head_o,
    output ptr_t   tail_o,
    output count_t readable_count_o,
    output logic   fetch_ready_o,
    output logic   buffer_empty_o,
    output logic   buffer_full_o,
    output count_t occupancy_o
);

    ptr_t   head;
    ptr_t   tail;
    count_t count;
    count_t free_space;

    //////////////////////////////////////////////////////////////////////
    // Pointer and count registers
    //////////////////////////////////////////////////////////////////////

    // Pointers are log2(depth) wide and wrap on their own
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else if (flush_i) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            head  <= head + ptr_t'(rd_count_i);
            tail  <= tail + ptr_t'(wr_count_i);
            count <= count + wr_count_i - rd_count_i;
        end
    end

    assign free_space = count_t'(`IBUF_DEPTH) - count;

    // Room for a full fetch group is required, whatever the mask
    assign fetch_ready_o = !flush_i && (free_space >= count_t'(`IBUF_FETCH_W));

    // Decode sees nothing during a flush
    assign readable_count_o = flush_i ? '0 : count;

    assign buffer_empty_o = (count == '0);
    assign buffer_full_o  = (count == count_t'(`IBUF_DEPTH));
    assign occupancy_o    = count;

    assign head_o = head;
    assign tail_o = tail;

endmodule

// File: verilog/ibuf_storage.sv
`timescale 1ns/1ps

`include "ibuf_consts.svh"

module ibuf_storage
    import ibuf_pkg::*;
(
    input  logic       clk,
    input  ptr_t       tail_i,
    input  ptr_t       head_i,
    input  lane_mask_t wr_en_i,
    input  ptr_t       wr_offset0_i,
    input  ptr_t       wr_offset1_i,
    input  ptr_t       wr_offset2_i,
    input  lane_mask_t rd_valid_i,
    input  ptr_t       rd_offset0_i,
    input  ptr_t       rd_offset1_i,
    input  ptr_t       rd_offset2_i,
    input  inst_t      fetch_inst0_i,
    input  inst_t      fetch_inst1_i,
    input  inst_t      fetch_inst2_i,
    input  addr_t      fetch_pc0_i,
    input  addr_t      fetch_pc1_i,
    input  addr_t      fetch_pc2_i,
    input  lane_mask_t fetch_pred_i,
    output inst_t      decode_inst0_o,
    output inst_t      decode_inst1_o,
    output inst_t      decode_inst2_o,
    output addr_t      decode_pc0_o,
    output addr_t      decode_pc1_o,
    output addr_t      decode_pc2_o,
    output lane_mask_t decode_pred_o
);

    // Entry arrays, one field per array
    inst_t inst_mem [`IBUF_DEPTH];
    addr_t pc_mem   [`IBUF_DEPTH];
    logic  pred_mem [`IBUF_DEPTH];

    inst_t wr_inst [`IBUF_FETCH_W];
    addr_t wr_pc   [`IBUF_FETCH_W];
    ptr_t  wr_addr [`IBUF_FETCH_W];
    ptr_t  rd_addr [`IBUF_DECODE_W];
    inst_t rd_inst [`IBUF_DECODE_W];
    addr_t rd_pc   [`IBUF_DECODE_W];

    assign wr_inst = '{fetch_inst0_i, fetch_inst1_i, fetch_inst2_i};
    assign wr_pc   = '{fetch_pc0_i, fetch_pc1_i, fetch_pc2_i};

    // Addresses wrap with the pointer width
    assign wr_addr = '{tail_i + wr_offset0_i, tail_i + wr_offset1_i, tail_i + wr_offset2_i};
    assign rd_addr = '{head_i + rd_offset0_i, head_i + rd_offset1_i, head_i + rd_offset2_i};

    //////////////////////////////////////////////////////////////////////
    // Write ports
    //////////////////////////////////////////////////////////////////////

    // Packed offsets keep the three addresses distinct
    always_ff @(posedge clk) begin
        for (int i = 0; i < `IBUF_FETCH_W; i++) begin
            if (wr_en_i[i]) begin
                inst_mem[wr_addr[i]] <= wr_inst[i];
                pc_mem[wr_addr[i]]   <= wr_pc[i];
                pred_mem[wr_addr[i]] <= fetch_pred_i[i];
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Read ports
    //////////////////////////////////////////////////////////////////////

    // Idle lanes show a NOP at PC zero
    always_comb begin
        for (int k = 0; k < `IBUF_DECODE_W; k++) begin
            rd_inst[k]       = rd_valid_i[k] ? inst_mem[rd_addr[k]] : `IBUF_NOP;
            rd_pc[k]         = rd_valid_i[k] ? pc_mem[rd_addr[k]] : '0;
            decode_pred_o[k] = rd_valid_i[k] & pred_mem[rd_addr[k]];
        end
    end

    assign decode_inst0_o = rd_inst[0];
    assign decode_inst1_o = rd_inst[1];
    assign decode_inst2_o = rd_inst[2];
    assign decode_pc0_o   = rd_pc[0];
    assign decode_pc1_o   = rd_pc[1];
    assign decode_pc2_o   = rd_pc[2];

endmodule

// File: verilog/instruction_buffer.sv
`timescale 1ns/1ps

`include "ibuf_consts.svh"

module instruction_buffer
    import ibuf_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       flush_i,
    input  lane_mask_t fetch_valid_i,
    input  inst_t      fetch_inst0_i,
    input  inst_t      fetch_inst1_i,
    input  inst_t      fetch_inst2_i,
    input  addr_t      fetch_pc0_i,
    input  addr_t      fetch_pc1_i,
    input  addr_t      fetch_pc2_i,
    input  lane_mask_t fetch_pred_i,
    output logic       fetch_ready_o,
    input  lane_mask_t decode_ready_i,
    output lane_mask_t decode_valid_o,
    output inst_t      decode_inst0_o,
    output inst_t      decode_inst1_o,
    output inst_t      decode_inst2_o,
    output addr_t      decode_pc0_o,
    output addr_t      decode_pc1_o,
    output addr_t      decode_pc2_o,
    output lane_mask_t decode_pred_o,
    output logic       buffer_empty_o,
    output logic       buffer_full_o,
    output count_t     occupancy_o
);

    // Fetch side
    lane_mask_t wr_en;
    ptr_t       wr_offset0, wr_offset1, wr_offset2;
    count_t     wr_count;

    // Decode side
    ptr_t       rd_offset0, rd_offset1, rd_offset2;
    count_t     rd_count;
    count_t     readable_count;

    ptr_t       head, tail;

    //////////////////////////////////////////////////////////////////////
    // Control
    //////////////////////////////////////////////////////////////////////

    ibuf_write_ctrl ibuf_write_ctrl_inst (
        .fetch_valid_i (fetch_valid_i),
        .fetch_ready_i (fetch_ready_o),
        .wr_en_o       (wr_en),
        .wr_offset0_o  (wr_offset0),
        .wr_offset1_o  (wr_offset1),
        .wr_offset2_o  (wr_offset2),
        .wr_count_o    (wr_count)
    );

    ibuf_read_ctrl ibuf_read_ctrl_inst (
        .decode_ready_i   (decode_ready_i),
        .readable_count_i (readable_count),
        .decode_valid_o   (decode_valid_o),
        .rd_offset0_o     (rd_offset0),
        .rd_offset1_o     (rd_offset1),
        .rd_offset2_o     (rd_offset2),
        .rd_count_o       (rd_count)
    );

    ibuf_occupancy ibuf_occupancy_inst (
        .clk              (clk),
        .reset            (reset),
        .flush_i          (flush_i),
        .wr_count_i       (wr_count),
        .rd_count_i       (rd_count),
        .head_o           (head),
        .tail_o           (tail),
        .readable_count_o (readable_count),
        .fetch_ready_o    (fetch_ready_o),
        .buffer_empty_o   (buffer_empty_o),
        .buffer_full_o    (buffer_full_o),
        .occupancy_o      (occupancy_o)
    );

    //////////////////////////////////////////////////////////////////////
    // Entry storage
    //////////////////////////////////////////////////////////////////////

    ibuf_storage ibuf_storage_inst (
        .clk            (clk),
        .tail_i         (tail),
        .head_i         (head),
        .wr_en_i        (wr_en),
        .wr_offset0_i   (wr_offset0),
        .wr_offset1_i   (wr_offset1),
        .wr_offset2_i   (wr_offset2),
        .rd_valid_i     (decode_valid_o),
        .rd_offset0_i   (rd_offset0),
        .rd_offset1_i   (rd_offset1),
        .rd_offset2_i   (rd_offset2),
        .fetch_inst0_i  (fetch_inst0_i),
        .fetch_inst1_i  (fetch_inst1_i),
        .fetch_inst2_i  (fetch_inst2_i),
        .fetch_pc0_i    (fetch_pc0_i),
        .fetch_pc1_i    (fetch_pc1_i),
        .fetch_pc2_i    (fetch_pc2_i),
        .fetch_pred_i   (fetch_pred_i),
        .decode_inst0_o (decode_inst0_o),
        .decode_inst1_o (decode_inst1_o),
        .decode_inst2_o (decode_inst2_o),
        .decode_pc0_o   (decode_pc0_o),
        .decode_pc1_o   (decode_pc1_o),
        .decode_pc2_o   (decode_pc2_o),
        .decode_pred_o  (decode_pred_o)
    );

endmodule

// File: testbench/ibuf_asserts.sv
`timescale 1ns/1ps

`include "ibuf_consts.svh"

module ibuf_asserts
    import ibuf_pkg::*;
(
    input logic       clk,
    input logic       reset,
    input logic       flush_i,
    input lane_mask_t fetch_valid_i,
    input logic       fetch_ready_i,
    input lane_mask_t decode_ready_i,
    input lane_mask_t decode_valid_i,
    input logic       buffer_empty_i,
    input logic       buffer_full_i,
    input count_t     occupancy_i
);

    int failures = 0;
    int accepted;
    int consumed;
    int next_occupancy;

    // Slots taken and lanes served on the coming edge
    assign accepted       = fetch_ready_i ? $countones(fetch_valid_i) : 0;
    assign consumed       = $countones(decode_valid_i);
    assign next_occupancy = int'(occupancy_i) + accepted - consumed;

    //////////////////////////////////////////////////////////////////////
    // Reset and status
    //////////////////////////////////////////////////////////////////////

    reset_values: assert property (@(posedge clk)
        $rose(reset) |-> occupancy_i == '0 && buffer_empty_i && !buffer_full_i &&
                         fetch_ready_i && decode_valid_i == '0)
        else begin
            $error("status outputs do not hold their reset values after reset");
            failures = failures + 1;
        end

    //////////////////////////////////////////////////////////////////////
    // Occupancy and lanes
    //////////////////////////////////////////////////////////////////////

    lane_needs_ready: assert property (@(posedge clk) disable iff (!reset)
        (decode_valid_i & ~decode_ready_i) == '0)
        else begin
            $error("a decode lane is valid without its ready bit");
            failures = failures + 1;
        end

    lanes_within_occupancy: assert property (@(posedge clk) disable iff (!reset)
        consumed <= int'(occupancy_i))
        else begin
            $error("more decode lanes are valid than entries are stored");
            failures = failures + 1;
        end

    occupancy_step: assert property (@(posedge clk) disable iff (!reset)
        !flush_i |=> int'(occupancy_i) == $past(next_occupancy))
        else begin
            $error("occupancy did not change by accepted slots minus served lanes");
            failures = failures + 1;
        end

    //////////////////////////////////////////////////////////////////////
    // Back-pressure and flush
    //////////////////////////////////////////////////////////////////////

    fetch_ready_rule: assert property (@(posedge clk) disable iff (!reset)
        fetch_ready_i == (!flush_i &&
                          occupancy_i <= count_t'(`IBUF_DEPTH - `IBUF_FETCH_W)))
        else begin
            $error("fetch ready does not follow the free space");
            failures = failures + 1;
        end

    nothing_stored_when_held: assert property (@(posedge clk) disable iff (!reset)
        (!fetch_ready_i && !flush_i && decode_valid_i == '0) |=> $stable(occupancy_i))
        else begin
            $error("an entry was stored while fetch was held off");
            failures = failures + 1;
        end

    flush_blocks: assert property (@(posedge clk) disable iff (!reset)
        flush_i |-> decode_valid_i == '0 && !fetch_ready_i)
        else begin
            $error("fetch or decode handshake active during a flush");
            failures = failures + 1;
        end

    flush_clears: assert property (@(posedge clk) disable iff (!reset)
        flush_i |=> occupancy_i == '0 && buffer_empty_i)
        else begin
            $error("buffer not empty on the cycle after a flush");
            failures = failures + 1;
        end

endmodule

bind instruction_buffer ibuf_asserts ibuf_asserts_inst (
    .clk            (clk),
    .reset          (reset),
    .flush_i        (flush_i),
    .fetch_valid_i  (fetch_valid_i),
    .fetch_ready_i  (fetch_ready_o),
    .decode_ready_i (decode_ready_i),
    .decode_valid_i (decode_valid_o),
    .buffer_empty_i (buffer_empty_o),
    .buffer_full_i  (buffer_full_o),
    .occupancy_i    (occupancy_o)
);

// File: testbench/tb_instruction_buffer.sv
`timescale 1ns/1ps

`include "ibuf_consts.svh"

module tb_instruction_buffer
    import ibuf_pkg::*;
();

    localparam int CLK_PERIOD    = 100;
    localparam int RESET_CYCLES  = 3;
    localparam int IDLE_CYCLES   = 4;
    localparam int RANDOM_CYCLES = 400;
    localparam int BP_CYCLES     = 20;
    localparam int FLUSH_CYCLES  = 20;
    localparam int TOTAL_CYCLES  = RESET_CYCLES + IDLE_CYCLES + RANDOM_CYCLES
                                   + BP_CYCLES + FLUSH_CYCLES;

    logic       clk;
    logic       reset;
    logic       flush_i;
    lane_mask_t fetch_valid_i;
    inst_t      fetch_inst0_i, fetch_inst1_i, fetch_inst2_i;
    addr_t      fetch_pc0_i, fetch_pc1_i, fetch_pc2_i;
    lane_mask_t fetch_pred_i;
    logic       fetch_ready_o;
    lane_mask_t decode_ready_i;
    lane_mask_t decode_valid_o;
    inst_t      decode_inst0_o, decode_inst1_o, decode_inst2_o;
    addr_t      decode_pc0_o, decode_pc1_o, decode_pc2_o;
    lane_mask_t decode_pred_o;
    logic       buffer_empty_o;
    logic       buffer_full_o;
    count_t     occupancy_o;

    // Reference queue of {pred, pc, inst} entries in fetch order
    logic [64:0] model_q [$];
    integer      seed;
    int          error_count;
    int          tests_run;
    int          cycles_checked;
    int          total_errors;

    instruction_buffer instruction_buffer_inst (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    task automatic report_error(input string msg);
        $display("[ERROR] %0t ns: %s", $time, msg);
        error_count++;
    endtask

    function automatic lane_mask_t random_mask();
        return lane_mask_t'($random(seed));
    endfunction

    // Compares the outputs with the queue, then applies the coming edge to it
    task automatic check_and_update();
        inst_t       out_inst [3];
        addr_t       out_pc [3];
        inst_t       in_inst [3];
        addr_t       in_pc [3];
        lane_mask_t  exp_valid;
        logic        exp_ready;
        logic [64:0] entry;
        int          readable;
        int          ready_seen;
        int          used;

        out_inst = '{decode_inst0_o, decode_inst1_o, decode_inst2_o};
        out_pc   = '{decode_pc0_o, decode_pc1_o, decode_pc2_o};
        in_inst  = '{fetch_inst0_i, fetch_inst1_i, fetch_inst2_i};
        in_pc    = '{fetch_pc0_i, fetch_pc1_i, fetch_pc2_i};
        cycles_checked++;

        // Ready lanes take stored entries in lane order
        readable   = flush_i ? 0 : model_q.size();
        ready_seen = 0;
        exp_valid  = '0;
        for (int k = 0; k < `IBUF_DECODE_W; k++) begin
            if (decode_ready_i[k]) begin
                ready_seen++;
                exp_valid[k] = (ready_seen <= readable);
            end
        end
        exp_ready = !flush_i && (`IBUF_DEPTH - model_q.size() >= `IBUF_FETCH_W);

        assert (occupancy_o == model_q.size())
            else report_error($sformatf("occupancy %0d, expected %0d",
                                        occupancy_o, model_q.size()));
        assert (buffer_empty_o == (model_q.size() == 0) &&
                buffer_full_o == (model_q.size() == `IBUF_DEPTH))
            else report_error($sformatf("empty/full %b/%b at occupancy %0d",
                                        buffer_empty_o, buffer_full_o, model_q.size()));
        assert (fetch_ready_o == exp_ready)
            else report_error($sformatf("fetch_ready %b, expected %b", fetch_ready_o, exp_ready));
        assert (decode_valid_o == exp_valid)
            else report_error($sformatf("decode_valid %b, expected %b",
                                        decode_valid_o, exp_valid));

        used = 0;
        for (int k = 0; k < `IBUF_DECODE_W; k++) begin
            if (exp_valid[k]) begin
                entry = model_q[used];
                used++;
                assert (out_inst[k] == entry[31:0] && out_pc[k] == entry[63:32] &&
                        decode_pred_o[k] == entry[64])
                    else report_error($sformatf("lane %0d shows %h/%h/%b, expected %h/%h/%b",
                                                k, out_inst[k], out_pc[k], decode_pred_o[k],
                                                entry[31:0], entry[63:32], entry[64]));
            end else begin
                assert (out_inst[k] == `IBUF_NOP && out_pc[k] == '0 && !decode_pred_o[k])
                    else report_error($sformatf("idle lane %0d shows %h/%h/%b",
                                                k, out_inst[k], out_pc[k], decode_pred_o[k]));
            end
        end
        repeat (used) void'(model_q.pop_front());

        // Valid slots are packed in slot order
        if (fetch_ready_o) begin
            for (int i = 0; i < `IBUF_FETCH_W; i++) begin
                if (fetch_valid_i[i])
                    model_q.push_back({fetch_pred_i[i], in_pc[i], in_inst[i]});
            end
        end
        if (flush_i)
            model_q.delete();
    endtask

    task automatic drive_cycle(input logic flush, input lane_mask_t valid,
                               input lane_mask_t ready);
        @(posedge clk);
        flush_i        <= flush;
        fetch_valid_i  <= valid;
        fetch_inst0_i  <= $random(seed);
        fetch_inst1_i  <= $random(seed);
        fetch_inst2_i  <= $random(seed);
        fetch_pc0_i    <= $random(seed);
        fetch_pc1_i    <= $random(seed);
        fetch_pc2_i    <= $random(seed);
        fetch_pred_i   <= random_mask();
        decode_ready_i <= ready;
        @(negedge clk);
        check_and_update();
    endtask

    task automatic drain_until_empty();
        while (!buffer_empty_o)
            drive_cycle(1'b0, 3'b000, 3'b111);
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        $display("Test %-16s finished, %0d errors so far", name, error_count);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        seed           = 32'h1264_9119;
        error_count    = 0;
        tests_run      = 0;
        cycles_checked = 0;
        reset          = 1'b0;
        flush_i        = 1'b0;
        fetch_valid_i  = '0;
        fetch_inst0_i  = '0;
        fetch_inst1_i  = '0;
        fetch_inst2_i  = '0;
        fetch_pc0_i    = '0;
        fetch_pc1_i    = '0;
        fetch_pc2_i    = '0;
        fetch_pred_i   = '0;
        // All lanes ask through reset, so a stale count would show as valid
        decode_ready_i = '1;

        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b1;

        // Decode asks while nothing is stored
        repeat (IDLE_CYCLES) drive_cycle(1'b0, 3'b000, 3'b111);
        finish_test("reset");

        repeat (RANDOM_CYCLES) drive_cycle(1'b0, random_mask(), random_mask());
        finish_test("ordered_delivery");

        // One single slot first, so full groups end exactly at the depth
        drain_until_empty();
        drive_cycle(1'b0, 3'b001, 3'b000);
        while (fetch_ready_o)
            drive_cycle(1'b0, 3'b111, 3'b000);
        repeat (3) drive_cycle(1'b0, 3'b111, 3'b000);
        assert (buffer_full_o)
            else report_error("buffer not full after fill with decode stalled");
        drain_until_empty();
        finish_test("back_pressure");

        repeat (3) drive_cycle(1'b0, 3'b111, 3'b000);
        drive_cycle(1'b1, 3'b111, 3'b111);
        drive_cycle(1'b0, 3'b000, 3'b000);
        assert (occupancy_o == '0 && buffer_empty_o)
            else report_error($sformatf("occupancy %0d after flush", occupancy_o));
        drive_cycle(1'b0, 3'b101, 3'b000);
        drive_cycle(1'b0, 3'b110, 3'b000);
        drain_until_empty();
        finish_test("flush");

        total_errors = error_count + instruction_buffer_inst.ibuf_asserts_inst.failures;
        $display("%0d tests, %0d cycles checked, %0d errors",
                 tests_run, cycles_checked, total_errors);
        if (total_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // Twice the expected run length
    initial begin
        #(2 * TOTAL_CYCLES * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d ns and was stopped",
                 2 * TOTAL_CYCLES * CLK_PERIOD);
        $display("TEST FAILED");
        $finish;
    end

endmodule

// File: all.f
+incdir+verilog
verilog/ibuf_pkg.sv
verilog/ibuf_write_ctrl.sv
verilog/ibuf_read_ctrl.sv
verilog/ibuf_occupancy.sv
verilog/ibuf_storage.sv
verilog/instruction_buffer.sv
testbench/ibuf_asserts.sv
testbench/tb_instruction_buffer.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_instruction_buffer
FILELIST  = all.f

OBJ_DIR   = obj_dir
SIM_BIN   = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
SOURCES   = $(shell grep -v '^+' $(FILELIST)) $(wildcard verilog/*.svh)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -qx 'TEST OK' $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
